// File: logic/cpuPkg.sv
// Shared widths, opcodes and bus control types for the bus CPU, referenced by scoped name
package cpuPkg;

    localparam int wordWidth = 32;
    localparam int addrWidth = 9;    // 512-word program memory
    localparam int regCount = 16;
    localparam int regIndexWidth = 4;
    localparam int stepsPerInstruction = 5;

    localparam logic [wordWidth-1:0] resetPc = '0;

    // Anything not listed here runs as a no-op
    typedef enum logic [4:0] {
        opIn   = 5'b10110,
        opOut  = 5'b10111,
        opMfhi = 5'b11000,
        opMflo = 5'b11001,
        opHalt = 5'b11011,
        opMthi = 5'b11100,
        opMtlo = 5'b11101
    } opcodeT;

    typedef struct packed {
        opcodeT                   opcode;   // 31:27
        logic [regIndexWidth-1:0] ra;       // 26:23
        logic [regIndexWidth-1:0] rb;       // 22:19
        logic [regIndexWidth-1:0] rc;       // 18:15
        logic [14:0]              constant; // Not used by these opcodes
    } instructionT;

    typedef enum logic [2:0] {
        idle = 3'd0,
        t0   = 3'd1,
        t1   = 3'd2,
        t2   = 3'd3,
        t3   = 3'd4,
        t4   = 3'd5
    } stepT;

    // One driver on the shared bus per step
    typedef enum logic [2:0] {
        srcNone   = 3'd0,
        srcPc     = 3'd1,
        srcMdr    = 3'd2,
        srcReg    = 3'd3,
        srcHi     = 3'd4,
        srcLo     = 3'd5,
        srcInPort = 3'd6
    } busSourceT;

    typedef struct packed {
        busSourceT busSource;
        logic      marIn;
        logic      mdrIn;
        logic      irIn;
        logic      pcIn;
        logic      regIn;
        logic      hiIn;
        logic      loIn;
        logic      outPortIn;
        logic      incPc;
        logic      read;
        logic      gra;       // Register index from ir.ra
        logic      grb;       // Register index from ir.rb
    } controlWordT;

endpackage

// File: logic/controlSequencer.sv
// Control step FSM that decodes IR and drives the control word for T0 to T4 of every instruction
`timescale 1ns/1ps

module controlSequencer (
    input  logic                clock,
    input  logic                rstN,
    input  logic                start,
    input  cpuPkg::instructionT ir,
    output cpuPkg::controlWordT control,
    output logic                halted
);

    cpuPkg::stepT step;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            step   <= cpuPkg::idle;
            halted <= 1'b1;
        end else begin
            case (step)
                cpuPkg::idle: begin
                    if (start) begin
                        step   <= cpuPkg::t0;
                        halted <= 1'b0;
                    end
                end
                cpuPkg::t0: step <= cpuPkg::t1;
                cpuPkg::t1: step <= cpuPkg::t2;
                cpuPkg::t2: step <= cpuPkg::t3;
                cpuPkg::t3: step <= cpuPkg::t4;
                cpuPkg::t4: begin
                    if (ir.opcode == cpuPkg::opHalt) begin
                        step   <= cpuPkg::idle;
                        halted <= 1'b1;
                    end else begin
                        step <= cpuPkg::t0;
                    end
                end
                default: step <= cpuPkg::idle;
            endcase
        end
    end

    always_comb begin
        control = '0;
        control.busSource = cpuPkg::srcNone;
        case (step)
            cpuPkg::idle: control.pcIn = start;   // Idle bus carries resetPc
            cpuPkg::t0: begin
                control.busSource = cpuPkg::srcPc;
                control.marIn     = 1'b1;
                control.incPc     = 1'b1;
            end
            cpuPkg::t1: begin
                control.read  = 1'b1;
                control.mdrIn = 1'b1;
            end
            cpuPkg::t2: begin
                control.busSource = cpuPkg::srcMdr;
                control.irIn      = 1'b1;
            end
            cpuPkg::t3: begin
                // Execute step
                case (ir.opcode)
                    cpuPkg::opMfhi: begin
                        control.busSource = cpuPkg::srcHi;
                        control.regIn     = 1'b1;
                        control.gra       = 1'b1;
                    end
                    cpuPkg::opMflo: begin
                        control.busSource = cpuPkg::srcLo;
                        control.regIn     = 1'b1;
                        control.gra       = 1'b1;
                    end
                    cpuPkg::opMthi: begin
                        control.busSource = cpuPkg::srcReg;
                        control.hiIn      = 1'b1;
                        control.gra       = 1'b1;
                    end
                    cpuPkg::opMtlo: begin
                        control.busSource = cpuPkg::srcReg;
                        control.loIn      = 1'b1;
                        control.gra       = 1'b1;
                    end
                    cpuPkg::opIn: begin
                        control.busSource = cpuPkg::srcInPort;
                        control.regIn     = 1'b1;
                        control.gra       = 1'b1;
                    end
                    cpuPkg::opOut: begin
                        control.busSource = cpuPkg::srcReg;
                        control.outPortIn = 1'b1;
                        control.gra       = 1'b1;
                    end
                    default: ;   // Halt and unknown opcodes do nothing here
                endcase
            end
            default: ;
        endcase
    end

    // Halted only ever pairs with the idle step
    assert property (@(posedge clock) disable iff (!rstN)
        !(halted && step == cpuPkg::t0));

    // A start during a run never reloads PC
    assert property (@(posedge clock) disable iff (!rstN)
        (start && !halted) |-> !control.pcIn);

endmodule

// File: logic/memoryUnit.sv
// MAR, MDR and program memory with a load port that fills words while the CPU is idle
`timescale 1ns/1ps

module memoryUnit (
    input  logic                          clock,
    input  logic                          rstN,
    input  cpuPkg::controlWordT           control,
    input  logic [cpuPkg::wordWidth-1:0]  bus,
    input  logic                          loadEnable,
    input  logic [cpuPkg::addrWidth-1:0]  loadAddress,
    input  logic [cpuPkg::wordWidth-1:0]  loadData,
    output logic [cpuPkg::wordWidth-1:0]  mdr
);

    localparam int depth = 1 << cpuPkg::addrWidth;

    logic [cpuPkg::wordWidth-1:0] memory [0:depth-1];
    logic [cpuPkg::addrWidth-1:0] mar;
    logic [cpuPkg::wordWidth-1:0] mdrReg;
    logic                         loadWrite;

    // A load that collides with a fetch read loses
    assign loadWrite = loadEnable && !control.read;

    always_ff @(posedge clock) begin
        if (loadWrite) begin
            memory[loadAddress] <= loadData;
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            mar <= '0;
        end else if (control.marIn) begin
            mar <= bus[cpuPkg::addrWidth-1:0];   // Low bits only
        end
    end

    // MDR takes the word at MAR on a read
    always_ff @(posedge clock) begin
        if (control.mdrIn && control.read) begin
            mdrReg <= memory[mar];
        end
    end

    assign mdr = mdrReg;

    // Loader and datapath must not touch memory together
    assert property (@(posedge clock) disable iff (!rstN)
        !(control.read && loadEnable));

endmodule

// File: logic/registerFile.sv
// General register file, index picked from IR fields by the gra and grb selects
`timescale 1ns/1ps

module registerFile (
    input  logic                          clock,
    input  logic                          rstN,
    input  cpuPkg::controlWordT           control,
    input  cpuPkg::instructionT           ir,
    input  logic [cpuPkg::wordWidth-1:0]  bus,
    output logic [cpuPkg::wordWidth-1:0]  regOut
);

    logic [cpuPkg::wordWidth-1:0]     regs [0:cpuPkg::regCount-1];
    logic [cpuPkg::regIndexWidth-1:0] regIndex;

    // Field select
    always_comb begin
        if (control.gra) begin
            regIndex = ir.ra;
        end else if (control.grb) begin
            regIndex = ir.rb;
        end else begin
            regIndex = '0;
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < cpuPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (control.regIn) begin
            regs[regIndex] <= bus;
        end
    end

    assign regOut = regs[regIndex];

    // One field select at a time
    assert property (@(posedge clock) disable iff (!rstN)
        !(control.gra && control.grb));

endmodule

// File: logic/busDatapath.sv
// PC, IR, HI, LO and output port around the shared bus, plus the bus multiplexer
`timescale 1ns/1ps

module busDatapath (
    input  logic                          clock,
    input  logic                          rstN,
    input  cpuPkg::controlWordT           control,
    input  logic [cpuPkg::wordWidth-1:0]  mdr,
    input  logic [cpuPkg::wordWidth-1:0]  regOut,
    input  logic [cpuPkg::wordWidth-1:0]  inPort,
    output logic [cpuPkg::wordWidth-1:0]  bus,
    output cpuPkg::instructionT           ir,
    output logic [cpuPkg::wordWidth-1:0]  outPort,
    output logic                          outStrobe
);

    logic [cpuPkg::wordWidth-1:0] pc;
    logic [cpuPkg::wordWidth-1:0] hi;
    logic [cpuPkg::wordWidth-1:0] lo;
    logic                         busLoad;

    always_comb begin
        case (control.busSource)
            cpuPkg::srcPc:     bus = pc;
            cpuPkg::srcMdr:    bus = mdr;
            cpuPkg::srcReg:    bus = regOut;
            cpuPkg::srcHi:     bus = hi;
            cpuPkg::srcLo:     bus = lo;
            cpuPkg::srcInPort: bus = inPort;   // Sampled straight off the pins
            default:           bus = cpuPkg::resetPc;   // Idle bus carries the restart address
        endcase
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc <= cpuPkg::resetPc;
        end else if (control.pcIn) begin
            pc <= bus;
        end else if (control.incPc) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            ir <= '0;
            hi <= '0;
            lo <= '0;
        end else begin
            if (control.irIn) ir <= cpuPkg::instructionT'(bus);
            if (control.hiIn) hi <= bus;
            if (control.loIn) lo <= bus;
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            outPort   <= '0;
            outStrobe <= 1'b0;
        end else begin
            outStrobe <= control.outPortIn;   // One cycle per out
            if (control.outPortIn) begin
                outPort <= bus;
            end
        end
    end

    // PC restart and MDR reads do not take their value from a bus driver
    assign busLoad = control.marIn | control.irIn | control.regIn | control.hiIn
                   | control.loIn | control.outPortIn;

    assert property (@(posedge clock) disable iff (!rstN)
        busLoad |-> control.busSource != cpuPkg::srcNone);

endmodule

// File: logic/cpuTop.sv
// Top of the bus CPU; ties sequencer, memory, register file and datapath together
`timescale 1ns/1ps

module cpuTop (
    input  logic                          clock,
    input  logic                          rstN,
    input  logic                          start,
    input  logic                          loadEnable,
    input  logic [cpuPkg::addrWidth-1:0]  loadAddress,
    input  logic [cpuPkg::wordWidth-1:0]  loadData,
    input  logic [cpuPkg::wordWidth-1:0]  inPort,
    output logic [cpuPkg::wordWidth-1:0]  outPort,
    output logic                          outStrobe,
    output logic                          halted
);

    cpuPkg::controlWordT          control;
    cpuPkg::instructionT          ir;
    logic [cpuPkg::wordWidth-1:0] bus;
    logic [cpuPkg::wordWidth-1:0] mdr;
    logic [cpuPkg::wordWidth-1:0] regOut;

    controlSequencer i_controlSequencer (
        .clock   (clock),
        .rstN    (rstN),
        .start   (start),
        .ir      (ir),
        .control (control),
        .halted  (halted)
    );

    // Loader side of the program memory
    memoryUnit i_memoryUnit (
        .clock       (clock),
        .rstN        (rstN),
        .control     (control),
        .bus         (bus),
        .loadEnable  (loadEnable),
        .loadAddress (loadAddress),
        .loadData    (loadData),
        .mdr         (mdr)
    );

    registerFile i_registerFile (
        .clock   (clock),
        .rstN    (rstN),
        .control (control),
        .ir      (ir),
        .bus     (bus),
        .regOut  (regOut)
    );

    busDatapath i_busDatapath (
        .clock     (clock),
        .rstN      (rstN),
        .control   (control),
        .mdr       (mdr),
        .regOut    (regOut),
        .inPort    (inPort),
        .bus       (bus),
        .ir        (ir),
        .outPort   (outPort),
        .outStrobe (outStrobe)
    );

endmodule

// File: testbench/cpuTb.sv
// Testbench for cpuTop, loads programs, runs them and checks outPort and halted against a model
`timescale 1ns/1ps

module cpuTb;

    localparam int clockPeriod = 100;
    localparam int resetCycles = 8;
    localparam int randomPrograms = 3;
    localparam int randomLength = 20;
    localparam int maxWords = 64;
    // Directed programs hold 3, 3 and 7 words, random ones add a halt
    localparam int totalWords = 13 + randomPrograms * (randomLength + 1);
    localparam int watchdogCycles =
        resetCycles + (cpuPkg::stepsPerInstruction + 2) * totalWords + 100;

    logic                          clock;
    logic                          rstN;
    logic                          start;
    logic                          loadEnable;
    logic [cpuPkg::addrWidth-1:0]  loadAddress;
    logic [cpuPkg::wordWidth-1:0]  loadData;
    logic [cpuPkg::wordWidth-1:0]  inPort;
    logic [cpuPkg::wordWidth-1:0]  outPort;
    logic                          outStrobe;
    logic                          halted;

    logic [31:0] lcgState = 32'hfd1b1aa9;
    logic [31:0] progWords [0:maxWords-1];
    logic [31:0] modelRegs [0:cpuPkg::regCount-1];   // Carried from run to run
    logic [31:0] modelHi;
    logic [31:0] modelLo;
    logic [31:0] expectedOuts [$];
    int          errorCount = 0;

    cpuTop i_dut (
        .clock       (clock),
        .rstN        (rstN),
        .start       (start),
        .loadEnable  (loadEnable),
        .loadAddress (loadAddress),
        .loadData    (loadData),
        .inPort      (inPort),
        .outPort     (outPort),
        .outStrobe   (outStrobe),
        .halted      (halted)
    );

    always #(clockPeriod / 2) clock = ~clock;

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] encode(input logic [4:0] opcode, input logic [3:0] ra,
                                           input logic [22:0] filler);
        return {opcode, ra, filler};
    endfunction

    // Six data opcodes plus the odd unknown one
    function automatic logic [31:0] randomInstruction();
        logic [31:0] pick;
        logic [31:0] fields;
        logic [4:0]  opcode;
        pick = nextRandom();
        fields = nextRandom();
        case (pick[31:16] % 7)
            0: opcode = cpuPkg::opIn;
            1: opcode = cpuPkg::opOut;
            2: opcode = cpuPkg::opMfhi;
            3: opcode = cpuPkg::opMflo;
            4: opcode = cpuPkg::opMthi;
            5: opcode = cpuPkg::opMtlo;
            default: opcode = 5'b00101;   // Undefined, acts as no-op
        endcase
        return encode(opcode, fields[30:27], fields[22:0]);
    endfunction

    // Walks the program from address 0 up to the halt, queueing every out value
    function automatic int referenceRun(input logic [31:0] inValue);
        int         pc;
        int         executed;
        logic [4:0] opcode;
        logic [3:0] ra;
        pc = 0;
        executed = 0;
        while (pc < maxWords) begin
            opcode = progWords[pc][31:27];
            ra = progWords[pc][26:23];
            pc++;
            executed++;
            case (opcode)
                cpuPkg::opIn:   modelRegs[ra] = inValue;
                cpuPkg::opOut:  expectedOuts.push_back(modelRegs[ra]);
                cpuPkg::opMfhi: modelRegs[ra] = modelHi;
                cpuPkg::opMflo: modelRegs[ra] = modelLo;
                cpuPkg::opMthi: modelHi = modelRegs[ra];
                cpuPkg::opMtlo: modelLo = modelRegs[ra];
                cpuPkg::opHalt: return executed;
                default: ;
            endcase
        end
        return executed;
    endfunction

    task automatic loadProgram(input int wordCount);
        for (int i = 0; i < wordCount; i++) begin
            @(posedge clock);
            loadEnable  <= 1'b1;
            loadAddress <= i[cpuPkg::addrWidth-1:0];
            loadData    <= progWords[i];
        end
        @(posedge clock);
        loadEnable <= 1'b0;
    endtask

    task automatic runProgram(input int wordCount, input logic [31:0] inValue);
        int expectedCycles;
        int cycles;
        loadProgram(wordCount);
        expectedCycles = cpuPkg::stepsPerInstruction * referenceRun(inValue);
        inPort <= inValue;   // Held for the whole run
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);    // Start sampled here
        start <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            @(negedge clock);
        end while (!halted && cycles < expectedCycles + 20);
        if (!halted) begin
            $display("halted did not rise within %0d cycles of start", cycles);
            errorCount++;
        end else if (cycles != expectedCycles) begin
            $display("Fail %0t halted cycles got %0d expected %0d", $time, cycles,
                     expectedCycles);
            errorCount++;
        end
        if (expectedOuts.size() != 0) begin
            $display("%0d expected out values never appeared on outPort", expectedOuts.size());
            errorCount++;
            expectedOuts.delete();
        end
    endtask

    // Compare process, checks each out strobe against the model queue
    always @(posedge clock) begin
        if (rstN && outStrobe) begin
            if (expectedOuts.size() == 0) begin
                $display("Unexpected out strobe at %0t with outPort %h", $time, outPort);
                errorCount++;
            end else begin
                if (outPort !== expectedOuts[0]) begin
                    $display("Fail %0t outPort got %h expected %h", $time, outPort,
                             expectedOuts[0]);
                    errorCount++;
                end
                void'(expectedOuts.pop_front());
            end
        end
    end

    initial begin
        clock = 1'b0;
        rstN = 1'b0;
        start = 1'b0;
        loadEnable = 1'b0;
        loadAddress = '0;
        loadData = '0;
        inPort = '0;
        modelHi = '0;
        modelLo = '0;
        for (int i = 0; i < cpuPkg::regCount; i++) begin
            modelRegs[i] = '0;
        end
        repeat (resetCycles) @(posedge clock);
        rstN <= 1'b1;
        @(negedge clock);
        if (halted !== 1'b1) begin
            $display("Fail %0t halted got %b expected 1", $time, halted);
            errorCount++;
        end
        if (outStrobe !== 1'b0) begin
            $display("Fail %0t outStrobe got %b expected 0", $time, outStrobe);
            errorCount++;
        end
        if (outPort !== '0) begin
            $display("Fail %0t outPort got %h expected %h", $time, outPort, 32'h0);
            errorCount++;
        end

        // in r3, out r3
        progWords[0] = encode(cpuPkg::opIn, 4'd3, '0);
        progWords[1] = encode(cpuPkg::opOut, 4'd3, '0);
        progWords[2] = encode(cpuPkg::opHalt, 4'd0, '0);
        runProgram(3, nextRandom());

        // HI gets one input value
        progWords[0] = encode(cpuPkg::opIn, 4'd5, '0);
        progWords[1] = encode(cpuPkg::opMthi, 4'd5, '0);
        progWords[2] = encode(cpuPkg::opHalt, 4'd0, '0);
        runProgram(3, nextRandom());

        // LO gets another, then both read back through other registers
        progWords[0] = encode(cpuPkg::opIn, 4'd6, '0);
        progWords[1] = encode(cpuPkg::opMtlo, 4'd6, '0);
        progWords[2] = encode(cpuPkg::opMfhi, 4'd7, '0);
        progWords[3] = encode(cpuPkg::opMflo, 4'd8, '0);
        progWords[4] = encode(cpuPkg::opOut, 4'd7, '0);
        progWords[5] = encode(cpuPkg::opOut, 4'd8, '0);
        progWords[6] = encode(cpuPkg::opHalt, 4'd0, '0);
        runProgram(7, nextRandom());

        for (int p = 0; p < randomPrograms; p++) begin
            for (int i = 0; i < randomLength; i++) begin
                progWords[i] = randomInstruction();
            end
            progWords[randomLength] = encode(cpuPkg::opHalt, 4'd0, '0);
            runProgram(randomLength + 1, nextRandom());
        end

        $display("Errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(watchdogCycles * clockPeriod);
        $display("Run timed out after %0d cycles without finishing", watchdogCycles);
        $display("Errors: %0d", errorCount);
        $display("tests failed");
        $finish;
    end

endmodule

// File: files.f
logic/cpuPkg.sv
logic/controlSequencer.sv
logic/memoryUnit.sv
logic/registerFile.sv
logic/busDatapath.sv
logic/cpuTop.sv
testbench/cpuTb.sv

// File: Bender.yml
package:
  name: bus_cpu

sources:
  - logic/cpuPkg.sv
  - logic/controlSequencer.sv
  - logic/memoryUnit.sv
  - logic/registerFile.sv
  - logic/busDatapath.sv
  - logic/cpuTop.sv
  - target: simulation
    files:
      - testbench/cpuTb.sv
